/* sources.f */
+incdir+tb
src/nand_cpu_pkg.sv
src/decoder.sv
src/register_file.sv
src/alu.sv
src/program_counter.sv
src/nand_cpu.sv
tb/nand_cpu_tb.sv

/* tb/nand_cpu_programs.svh */
`ifndef NAND_CPU_PROGRAMS_SVH
`define NAND_CPU_PROGRAMS_SVH

// Program image, byte 0 first; 8'hff bytes sit where no branch should land
localparam int IMAGE_LEN = 39;
localparam logic [8*IMAGE_LEN-1:0] IMAGE = {
    8'h85, 8'h01, 8'h8c, 8'h11, 8'hd1, 8'h00, 8'h82, 8'hab,   // NND result, then LI twice
    8'h02, 8'h21, 8'hd2, 8'h32, 8'hd1, 8'h03, 8'h43, 8'h00,   // LS, RS stores, EQ
    8'h94, 8'h04, 8'h64, 8'hff, 8'h54, 8'h63, 8'ha0, 8'h05,   // BR taken, NE, BR not taken
    8'h75, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff,   // JRL to 0x20
    8'hd5, 8'hc1, 8'hd5, 8'he9, 8'h00, 8'hf0, 8'hd1           // Link store, LD, INT, HLT
};

// One word per step, step 0 first: pc, mem_addr, mem_wdata, flags
// Flags are halted, int_valid, mem_we, unused, then the 4-bit int_code
localparam int NUM_STEPS = 34;
localparam logic [32*NUM_STEPS-1:0] STEPS = {
    32'h00000000, 32'h01000000, 32'h02000000, 32'h03000000,
    32'h0405fb20, 32'h05000000, 32'h06000000, 32'h07000000,
    32'h08000000, 32'h09000000, 32'h0aab6020, 32'h0b000000,
    32'h0c050c20, 32'h0d000000, 32'h0e000000, 32'h0f000000,
    32'h10000000, 32'h11000000, 32'h12000000, 32'h14000000,
    32'h15000000, 32'h16000000, 32'h17000000, 32'h18000000,
    32'h20192020, 32'h21000000, 32'h22190c20, 32'h23000049,
    32'h24000000, 32'h25000000, 32'h26000080, 32'h26000080,
    32'h26000080, 32'h26000080
};

`endif

/* tb/nand_cpu_tb.sv */
module nand_cpu_tb;

    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 3;
    localparam int MEM_DEPTH  = 256;

    `include "nand_cpu_programs.svh"

    logic                                clk;
    logic                                rst;
    logic [nand_cpu_pkg::INSTR_W-1:0]    instr;
    logic [nand_cpu_pkg::DATA_W-1:0]     pc;
    logic [nand_cpu_pkg::DATA_W-1:0]     mem_addr;
    logic [nand_cpu_pkg::DATA_W-1:0]     mem_wdata;
    logic                                mem_we;
    logic [nand_cpu_pkg::DATA_W-1:0]     mem_rdata;
    logic                                int_valid;
    logic [nand_cpu_pkg::IMM4_W-1:0]     int_code;
    logic                                halted;

    logic [nand_cpu_pkg::INSTR_W-1:0]    rom [MEM_DEPTH];
    logic [nand_cpu_pkg::DATA_W-1:0]     ram [MEM_DEPTH];

    nand_cpu u_nand_cpu (
        .clk       (clk),
        .rst       (rst),
        .instr     (instr),
        .pc        (pc),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .mem_rdata (mem_rdata),
        .int_valid (int_valid),
        .int_code  (int_code),
        .halted    (halted)
    );

    assign instr     = rom[pc];                     // Async ROM
    assign mem_rdata = ram[mem_addr];

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        if (mem_we) begin
            ram[mem_addr] <= mem_wdata;
        end
    end

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %0t %s: got %0h, expected %0h", $time, what, actual, expected);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch on %s", what);
        end
    endtask

    task automatic load_memories();
        int i;
        for (i = 0; i < MEM_DEPTH; i++) begin
            rom[i] = i[7:0] ^ 8'h3c;                // Fill, overwritten by the image below
            ram[i] = i[7:0] ^ 8'ha5;
        end
        for (i = 0; i < IMAGE_LEN; i++) begin
            rom[i] = IMAGE[8*(IMAGE_LEN-1-i) +: 8];
        end
    endtask

    initial begin : run_steps
        logic [31:0] step;
        int          k;
        rst = 1'b1;
        load_memories();
        repeat (RST_CYCLES - 1) begin
            @(negedge clk);
            check_value("pc in reset", pc, 8'h00);
            check_value("halted in reset", halted, 1'b0);
        end
        @(posedge clk);
        rst <= 1'b0;
        for (k = 0; k < NUM_STEPS; k++) begin
            step = STEPS[32*(NUM_STEPS-1-k) +: 32];
            @(negedge clk);                         // Outputs settled mid cycle
            check_value($sformatf("step %0d pc", k), pc, step[31:24]);
            check_value($sformatf("step %0d halted", k), halted, step[7]);
            check_value($sformatf("step %0d int_valid", k), int_valid, step[6]);
            check_value($sformatf("step %0d mem_we", k), mem_we, step[5]);
            if (step[5]) begin
                check_value($sformatf("step %0d mem_addr", k), mem_addr, step[23:16]);
                check_value($sformatf("step %0d mem_wdata", k), mem_wdata, step[15:8]);
            end
            if (step[6]) begin
                check_value($sformatf("step %0d int_code", k), int_code, step[3:0]);
            end
        end
        $display("TESTS PASSED");
        $finish;
    end

    initial begin : watchdog
        #((NUM_STEPS + 10) * CLK_PERIOD);
        $display("Timeout: the step table did not finish within %0d cycles", NUM_STEPS + 10);
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

/* src/nand_cpu.sv */
module nand_cpu (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [nand_cpu_pkg::INSTR_W-1:0]   instr,
    output logic [nand_cpu_pkg::DATA_W-1:0]    pc,
    output logic [nand_cpu_pkg::DATA_W-1:0]    mem_addr,
    output logic [nand_cpu_pkg::DATA_W-1:0]    mem_wdata,
    output logic                               mem_we,
    input  logic [nand_cpu_pkg::DATA_W-1:0]    mem_rdata,
    output logic                               int_valid,
    output logic [nand_cpu_pkg::IMM4_W-1:0]    int_code,
    output logic                               halted
);

    logic                               write_a;
    logic                               write_r;
    logic                               interrupt;
    logic                               halt;
    logic [nand_cpu_pkg::REG_SEL_W-1:0] r_sel;
    logic [nand_cpu_pkg::IMM4_W-1:0]    immdt4;
    logic [nand_cpu_pkg::IMM6_W-1:0]    immdt6;
    nand_cpu_pkg::alu_op_e              op;
    logic [nand_cpu_pkg::DATA_W-1:0]    r_data;
    logic [nand_cpu_pkg::DATA_W-1:0]    a_data;
    logic [nand_cpu_pkg::DATA_W-1:0]    a_next;
    logic                               cmp;
    logic [nand_cpu_pkg::DATA_W-1:0]    link;
    logic [nand_cpu_pkg::DATA_W-1:0]    r_wdata;
    logic                               active;

    decoder u_decoder (
        .instr     (instr),
        .read_a    (),
        .write_a   (write_a),
        .read_r    (),
        .write_r   (write_r),
        .use_immdt (),
        .interrupt (interrupt),
        .halt      (halt),
        .r_sel     (r_sel),
        .immdt4    (immdt4),
        .immdt6    (immdt6),
        .op        (op)
    );

    assign active  = !rst && !halted;                // Nothing retires otherwise
    assign r_wdata = (op == nand_cpu_pkg::ALU_JRL) ? link : a_data;

    register_file u_register_file (
        .clk     (clk),
        .rst     (rst),
        .r_sel   (r_sel),
        .write_r (write_r && active),
        .write_a (write_a && active),
        .r_wdata (r_wdata),
        .a_wdata (a_next),
        .r_data  (r_data),
        .a_data  (a_data)
    );

    alu u_alu (
        .op        (op),
        .a_data    (a_data),
        .r_data    (r_data),
        .immdt6    (immdt6),
        .mem_rdata (mem_rdata),
        .a_next    (a_next),
        .cmp       (cmp)
    );

    program_counter u_program_counter (
        .clk    (clk),
        .rst    (rst),
        .op     (op),
        .cmp    (cmp),
        .r_data (r_data),
        .pc     (pc),
        .link   (link),
        .halted (halted)
    );

    assign mem_addr  = r_data;
    assign mem_wdata = a_data;
    assign mem_we    = (op == nand_cpu_pkg::ALU_ST) && active;
    assign int_valid = interrupt && active;
    assign int_code  = immdt4;

    // HLT must retire with a normal pc step before the freeze
    a_halt_retire: assert property (@(posedge clk) disable iff (rst)
        halt && !halted |=> halted && (pc == $past(link)))
        else $error("nand_cpu: HLT did not stop the core");

endmodule

/* src/program_counter.sv */
module program_counter (
    input  logic                            clk,
    input  logic                            rst,
    input  nand_cpu_pkg::alu_op_e           op,
    input  logic                            cmp,
    input  logic [nand_cpu_pkg::DATA_W-1:0] r_data,
    output logic [nand_cpu_pkg::DATA_W-1:0] pc,
    output logic [nand_cpu_pkg::DATA_W-1:0] link,
    output logic                            halted
);

    logic                            flag;
    logic                            take;
    logic [nand_cpu_pkg::DATA_W-1:0] pc_next;

    assign link = pc + nand_cpu_pkg::DATA_W'(1);      // Wraps at 8 bits

    assign take = (op == nand_cpu_pkg::ALU_JRL) ||
                  ((op == nand_cpu_pkg::ALU_BR) && flag);

    assign pc_next = take ? r_data : link;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc     <= '0;
            flag   <= 1'b0;
            halted <= 1'b0;
        end else if (!halted) begin
            pc <= pc_next;
            if ((op == nand_cpu_pkg::ALU_EQ) || (op == nand_cpu_pkg::ALU_NE)) begin
                flag <= cmp;
            end
            if (op == nand_cpu_pkg::ALU_HLT) begin
                halted <= 1'b1;                      // Sticky until reset
            end
        end
    end

    a_pc_frozen: assert property (@(posedge clk) disable iff (rst) halted |=> $stable(pc))
        else $error("program_counter: pc moved while halted");

endmodule

/* src/alu.sv */
module alu (
    input  nand_cpu_pkg::alu_op_e           op,
    input  logic [nand_cpu_pkg::DATA_W-1:0] a_data,
    input  logic [nand_cpu_pkg::DATA_W-1:0] r_data,
    input  logic [nand_cpu_pkg::IMM6_W-1:0] immdt6,
    input  logic [nand_cpu_pkg::DATA_W-1:0] mem_rdata,
    output logic [nand_cpu_pkg::DATA_W-1:0] a_next,
    output logic                            cmp
);

    logic [nand_cpu_pkg::SHAMT_W-1:0] shamt;

    assign shamt = r_data[nand_cpu_pkg::SHAMT_W-1:0];

    always_comb begin
        case (op)
            nand_cpu_pkg::ALU_CLR: begin
                a_next = '0;
            end
            nand_cpu_pkg::ALU_NND: begin
                a_next = ~(a_data & r_data);
            end
            nand_cpu_pkg::ALU_LS: begin
                a_next = a_data << shamt;            // Logical, zero fill
            end
            nand_cpu_pkg::ALU_RS: begin
                a_next = a_data >> shamt;
            end
            nand_cpu_pkg::ALU_LI: begin
                // Old A moves up by six, immediate fills the bottom
                a_next = {a_data[nand_cpu_pkg::DATA_W-nand_cpu_pkg::IMM6_W-1:0], immdt6};
            end
            nand_cpu_pkg::ALU_LD: begin
                a_next = mem_rdata;
            end
            default: begin
                a_next = a_data;                     // A unchanged
            end
        endcase
    end

    // NE inverts the equality test
    assign cmp = (op == nand_cpu_pkg::ALU_NE) ? (a_data != r_data) : (a_data == r_data);

endmodule

/* src/register_file.sv */
module register_file (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [nand_cpu_pkg::REG_SEL_W-1:0] r_sel,
    input  logic                               write_r,
    input  logic                               write_a,
    input  logic [nand_cpu_pkg::DATA_W-1:0]    r_wdata,
    input  logic [nand_cpu_pkg::DATA_W-1:0]    a_wdata,
    output logic [nand_cpu_pkg::DATA_W-1:0]    r_data,
    output logic [nand_cpu_pkg::DATA_W-1:0]    a_data
);

    logic [nand_cpu_pkg::DATA_W-1:0] regs [nand_cpu_pkg::NUM_REG];
    logic [nand_cpu_pkg::DATA_W-1:0] acc;

    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
            for (int i = 0; i < nand_cpu_pkg::NUM_REG; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (write_a) begin
                acc <= a_wdata;
            end
            if (write_r) begin
                regs[r_sel] <= r_wdata;
            end
        end
    end

    assign r_data = regs[r_sel];                 // Async read port
    assign a_data = acc;

    // Top level is expected to mask strobes while in reset
    a_no_write_in_rst: assert property (@(posedge clk) rst |-> !(write_r || write_a))
        else $error("register_file: write strobe during reset");

endmodule

/* src/decoder.sv */
module decoder (
    input  logic [nand_cpu_pkg::INSTR_W-1:0]   instr,
    output logic                               read_a,
    output logic                               write_a,
    output logic                               read_r,
    output logic                               write_r,
    output logic                               use_immdt,
    output logic                               interrupt,
    output logic                               halt,
    output logic [nand_cpu_pkg::REG_SEL_W-1:0] r_sel,
    output logic [nand_cpu_pkg::IMM4_W-1:0]    immdt4,
    output logic [nand_cpu_pkg::IMM6_W-1:0]    immdt6,
    output nand_cpu_pkg::alu_op_e              op
);

    always_comb begin
        read_a    = 1'b0;
        write_a   = 1'b0;
        read_r    = 1'b0;
        write_r   = 1'b0;
        use_immdt = 1'b0;
        op        = nand_cpu_pkg::ALU_CLR;
        r_sel     = instr[nand_cpu_pkg::REG_SEL_W-1:0];
        immdt4    = instr[nand_cpu_pkg::IMM4_W-1:0];
        immdt6    = instr[nand_cpu_pkg::IMM6_W-1:0];
        interrupt = (instr[7:4] == 4'b1110);
        halt      = (instr[7:4] == 4'b1111);

        priority casez (instr)
            8'b0000_0000: begin             // CL
                write_a = 1'b1;
                op      = nand_cpu_pkg::ALU_CLR;
            end
            8'b0000_????: begin             // CP, r <- A
                read_a  = 1'b1;
                write_r = 1'b1;
                op      = nand_cpu_pkg::ALU_CP;
            end
            8'b0001_????: begin             // NND
                read_a  = 1'b1;
                write_a = 1'b1;
                read_r  = 1'b1;
                op      = nand_cpu_pkg::ALU_NND;
            end
            8'b0010_????: begin             // LS
                read_a  = 1'b1;
                write_a = 1'b1;
                read_r  = 1'b1;
                op      = nand_cpu_pkg::ALU_LS;
            end
            8'b0011_????: begin             // RS
                read_a  = 1'b1;
                write_a = 1'b1;
                read_r  = 1'b1;
                op      = nand_cpu_pkg::ALU_RS;
            end
            8'b0100_????: begin             // EQ
                read_a = 1'b1;
                read_r = 1'b1;
                op     = nand_cpu_pkg::ALU_EQ;
            end
            8'b0101_????: begin             // NE
                read_a = 1'b1;
                read_r = 1'b1;
                op     = nand_cpu_pkg::ALU_NE;
            end
            8'b0110_????: begin             // BR
                read_r = 1'b1;
                op     = nand_cpu_pkg::ALU_BR;
            end
            8'b0111_????: begin             // JRL, r gets the link
                read_r  = 1'b1;
                write_r = 1'b1;
                op      = nand_cpu_pkg::ALU_JRL;
            end
            8'b10??_????: begin             // LI
                read_a    = 1'b1;
                write_a   = 1'b1;
                use_immdt = 1'b1;
                op        = nand_cpu_pkg::ALU_LI;
            end
            8'b1100_????: begin             // LD
                read_a  = 1'b1;
                write_a = 1'b1;
                read_r  = 1'b1;
                op      = nand_cpu_pkg::ALU_LD;
            end
            8'b1101_????: begin             // ST
                read_a = 1'b1;
                read_r = 1'b1;
                op     = nand_cpu_pkg::ALU_ST;
            end
            8'b1110_????: begin             // INT
                use_immdt = 1'b1;
                op        = nand_cpu_pkg::ALU_INT;
            end
            8'b1111_????: begin             // HLT
                use_immdt = 1'b1;
                op        = nand_cpu_pkg::ALU_HLT;
            end
            default: begin
                op = nand_cpu_pkg::ALU_CLR;
            end
        endcase

        // Every known opcode byte must land on a defined operation
        if (!$isunknown(instr)) begin
            assert (!$isunknown(op))
                else $error("decoder: unknown op for instr %h", instr);
        end
    end

endmodule

/* src/nand_cpu_pkg.sv */
package nand_cpu_pkg;

    localparam int DATA_W    = 8;                 // Data and address width
    localparam int INSTR_W   = 8;
    localparam int NUM_REG   = 16;
    localparam int REG_SEL_W = $clog2(NUM_REG);
    localparam int IMM4_W    = 4;                 // INT code field
    localparam int IMM6_W    = 6;                 // LI payload field
    localparam int SHAMT_W   = 3;                 // Shift amount bits taken from r

    // One operation per instruction class
    typedef enum logic [3:0] {
        ALU_CLR,
        ALU_CP,
        ALU_NND,
        ALU_LS,
        ALU_RS,
        ALU_EQ,
        ALU_NE,
        ALU_BR,
        ALU_JRL,
        ALU_LI,
        ALU_LD,
        ALU_ST,
        ALU_INT,
        ALU_HLT
    } alu_op_e;

endpackage
